// ==== all.f ====
+incdir+include
logic/video_pkg.sv
logic/delay_line.sv
logic/dual_port_ram.sv
logic/glyph_rom.sv
logic/pixel_mixer.sv
logic/ram_to_video.sv
logic/video_out_top.sv
testbench/tb_clock.sv
testbench/tb_video_out.sv

// ==== include/glyph_font.svh ====
// 8x8 hex digit font, entry is code * 8 + row
// bit 7 is the leftmost pixel of a row
localparam logic [7:0] glyph_font [0:127] = '{
    // 0 to 3
    8'h3c, 8'h66, 8'h6e, 8'h76, 8'h66, 8'h66, 8'h3c, 8'h00,
    8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7e, 8'h00,
    8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e, 8'h00,
    8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c, 8'h00,
    // 4 to 7
    8'h0c, 8'h1c, 8'h3c, 8'h6c, 8'h7e, 8'h0c, 8'h0c, 8'h00,
    8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c, 8'h00,
    8'h1c, 8'h30, 8'h60, 8'h7c, 8'h66, 8'h66, 8'h3c, 8'h00,
    8'h7e, 8'h06, 8'h0c, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00,
    // 8 to b
    8'h3c, 8'h66, 8'h66, 8'h3c, 8'h66, 8'h66, 8'h3c, 8'h00,
    8'h3c, 8'h66, 8'h66, 8'h3e, 8'h06, 8'h0c, 8'h38, 8'h00,
    8'h18, 8'h3c, 8'h66, 8'h66, 8'h7e, 8'h66, 8'h66, 8'h00,
    8'h7c, 8'h66, 8'h66, 8'h7c, 8'h66, 8'h66, 8'h7c, 8'h00,
    // c to f
    8'h3c, 8'h66, 8'h60, 8'h60, 8'h60, 8'h66, 8'h3c, 8'h00,
    8'h78, 8'h6c, 8'h66, 8'h66, 8'h66, 8'h6c, 8'h78, 8'h00,
    8'h7e, 8'h60, 8'h60, 8'h7c, 8'h60, 8'h60, 8'h7e, 8'h00,
    8'h7e, 8'h60, 8'h60, 8'h7c, 8'h60, 8'h60, 8'h60, 8'h00
};

// ==== logic/delay_line.sv ====
module delay_line #(
    parameter type payload_t = logic,
    parameter int cycles = 1,
    parameter payload_t idle = '0
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t in,
    output payload_t out
);

    payload_t stages [cycles];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cycles; i++) begin
                stages[i] <= idle;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < cycles; i++) begin
                stages[i] <= stages[i - 1];
            end
        end
    end

    assign out = stages[cycles - 1];

endmodule

// ==== logic/dual_port_ram.sv ====
module dual_port_ram #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 16
) (
    input  logic                     clock,
    input  logic                     write,
    input  logic [$clog2(depth)-1:0] write_address,
    input  payload_t                 write_data,
    input  logic [$clog2(depth)-1:0] read_address,
    output payload_t                 read_data
);

    payload_t memory [depth];

    // write port
    always_ff @(posedge clock) begin
        if (write) begin
            memory[write_address] <= write_data;
        end
    end

    // read port, one clock of latency
    always_ff @(posedge clock) begin
        read_data <= memory[read_address];
    end

    // a bad address would corrupt an unknown word
    write_address_known: assert property (
        @(posedge clock) write |-> !$isunknown(write_address)
    );

endmodule

// ==== logic/glyph_rom.sv ====
module glyph_rom
    import video_pkg::*;
(
    input  logic                       clock,
    input  char_t                      code,
    input  logic [glyph_row_width-1:0] row,
    output logic [7:0]                 bits
);

    `include "glyph_font.svh"

    logic [6:0] address;

    // low nibble of the code picks one of 16 glyphs
    assign address = {code[3:0], row};

    always_ff @(posedge clock) begin
        bits <= glyph_font[address];
    end

endmodule

// ==== logic/pixel_mixer.sv ====
module pixel_mixer
    import video_pkg::*;
(
    input  logic       clock,
    input  logic       draw,
    input  logic       text_area,
    input  logic       char_pixel,
    input  logic       scanline,
    input  logic [7:0] scanline_intensity,
    input  pixel_t     pixel,
    output pixel_t     mixed
);

    // channel times intensity, high byte kept
    function automatic logic [7:0] scale(
        input logic [7:0] channel,
        input logic [7:0] factor
    );
        logic [15:0] product;
        product = channel * factor;
        return product[15:8];
    endfunction

    always_ff @(posedge clock) begin
        if (!draw) begin
            mixed <= '0;
        end else if (text_area) begin
            if (char_pixel) begin
                mixed <= osd_text_color;
            end else begin
                // dimmed background behind the text
                mixed <= {pixel[23:16] >> 1, pixel[15:8] >> 1, pixel[7:0] >> 1};
            end
        end else if (scanline) begin
            mixed <= {
                scale(pixel[23:16], scanline_intensity),
                scale(pixel[15:8], scanline_intensity),
                scale(pixel[7:0], scanline_intensity)
            };
        end else begin
            mixed <= pixel;
        end
    end

endmodule

// ==== logic/ram_to_video.sv ====
module ram_to_video
    import video_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           start_trigger,
    input  logic                           line_doubler,
    input  logic                           osd_enable,
    input  logic                           osd_highlight,
    input  logic                           scanline_enable,
    input  logic                           scanline_odd,
    input  logic [7:0]                     scanline_intensity,
    input  pixel_t                         pixel_read_data,
    input  char_t                          text_read_data,
    output logic [pixel_address_width-1:0] pixel_read_address,
    output logic [text_address_width-1:0]  text_read_address,
    output pixel_t                         video_out,
    output logic                           hsync,
    output logic                           vsync,
    output logic                           draw_area,
    output logic                           settled
);

    logic                           running;
    logic [h_count_width-1:0]       x;
    logic [v_count_width-1:0]       y;
    logic [pixel_address_width-1:0] line_base;

    logic                           in_draw;
    logic                           in_text;
    logic                           on_scanline;
    logic                           hsync_now;
    logic                           vsync_now;
    logic [v_count_width-1:0]       row_offset;

    logic [2:0]                     sync_early;
    logic [5:0]                     flags_early;

    logic [pixel_address_width-1:0] fetch_address [3];
    logic [text_address_width-1:0]  fetch_column [2];
    logic [glyph_row_width-1:0]     fetch_row [4];

    logic [7:0]                     glyph_bits;
    logic                           draw_late;
    logic                           text_late;
    logic                           scan_late;
    logic [2:0]                     x_late;
    logic                           char_pixel;

    logic                           vsync_last;
    logic                           vsync_begin;
    logic [$clog2(settle_frames)-1:0] vsync_count;
    logic                           settled_reg;

    //////////////////////////////////////////////////////////////////////
    // pixel counters and line base
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            x <= '0;
            y <= '0;
            line_base <= '0;
        end else if (!running) begin
            // idle until the first start strobe
            if (start_trigger) begin
                running <= 1'b1;
                x <= '0;
                y <= '0;
                line_base <= '0;
            end
        end else if (x == h_total - 1) begin
            x <= '0;
            if (y == v_total - 1) begin
                y <= '0;
                line_base <= '0;
            end else begin
                y <= y + 1'b1;
                // every second line only when doubling
                if (y < v_visible - 1 && (!line_doubler || y[0])) begin
                    line_base <= line_base + pixel_address_width'(buffer_line_length);
                end
            end
        end else begin
            x <= x + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // area flags and sync levels for the current counter value
    assign in_draw = running && x < h_visible && y < v_visible;
    assign in_text = in_draw && osd_enable
        && x >= osd_x_start && x < osd_x_end
        && y >= osd_y_start && y < osd_y_end;
    assign on_scanline = scanline_enable && ((line_doubler ? y[1] : y[0]) == scanline_odd);
    assign hsync_now = (running && x >= hsync_start && x < hsync_start + hsync_width)
        ? sync_active : ~sync_active;
    assign vsync_now = (running && y >= vsync_start && y < vsync_start + vsync_width)
        ? sync_active : ~sync_active;
    assign row_offset = y - v_count_width'(osd_y_start);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync_early <= sync_bundle_idle;
            flags_early <= '0;
        end else begin
            sync_early <= {in_draw, hsync_now, vsync_now};
            flags_early <= {in_draw, in_text, on_scanline, x[2:0]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read addresses timed so pixel and glyph row land together
    always_ff @(posedge clock) begin
        fetch_address[0] <= in_draw ? line_base + pixel_address_width'(x) : '0;
        fetch_address[1] <= fetch_address[0];
        fetch_address[2] <= fetch_address[1];
        pixel_read_address <= fetch_address[2];

        // one character per 8 pixels
        fetch_column[0] <= x[3 +: text_address_width];
        fetch_column[1] <= fetch_column[0];
        text_read_address <= fetch_column[1];

        fetch_row[0] <= row_offset[glyph_row_width-1:0];
        fetch_row[1] <= fetch_row[0];
        fetch_row[2] <= fetch_row[1];
        fetch_row[3] <= fetch_row[2];
    end

    glyph_rom font (
        .clock(clock),
        .code (text_read_data),
        .row  (fetch_row[3]),
        .bits (glyph_bits)
    );

    delay_line #(
        .payload_t(logic [5:0]),
        .cycles   (pixel_latency - 2),
        .idle     (6'b0)
    ) flags_delay (
        .clock(clock),
        .reset(reset),
        .in   (flags_early),
        .out  ({draw_late, text_late, scan_late, x_late})
    );

    assign char_pixel = glyph_bits[3'd7 - x_late] ^ osd_highlight;

    pixel_mixer mixer (
        .clock             (clock),
        .draw              (draw_late),
        .text_area         (text_late),
        .char_pixel        (char_pixel),
        .scanline          (scan_late),
        .scanline_intensity(scanline_intensity),
        .pixel             (pixel_read_data),
        .mixed             (video_out)
    );

    delay_line #(
        .payload_t(logic [2:0]),
        .cycles   (pixel_latency - 1),
        .idle     (sync_bundle_idle)
    ) sync_delay (
        .clock(clock),
        .reset(reset),
        .in   (sync_early),
        .out  ({draw_area, hsync, vsync})
    );

    //////////////////////////////////////////////////////////////////////
    // settled after a few vsync pulses at the port
    assign vsync_begin = vsync == sync_active && vsync_last != sync_active;
    assign settled = settled_reg || (vsync_begin && vsync_count == settle_frames - 1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vsync_last <= ~sync_active;
            vsync_count <= '0;
            settled_reg <= 1'b0;
        end else begin
            vsync_last <= vsync;
            if (vsync_begin && !settled_reg) begin
                vsync_count <= vsync_count + 1'b1;
            end
            settled_reg <= settled;
        end
    end

    hsync_pulse_width: assert property (
        @(posedge clock) disable iff (reset)
        (hsync == sync_active && $past(hsync) != sync_active)
            |-> (hsync == sync_active)[*hsync_width] ##1 (hsync != sync_active)
    );

    // the line base must not run past the last buffer row
    read_address_in_range: assert property (
        @(posedge clock) disable iff (reset)
        in_draw |-> int'(line_base) + int'(x) < pixel_depth
    );

endmodule

// ==== logic/video_out_top.sv ====
module video_out_top
    import video_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           start_trigger,
    input  logic                           line_doubler,
    input  logic                           osd_enable,
    input  logic                           osd_highlight,
    input  logic                           scanline_enable,
    input  logic                           scanline_odd,
    input  logic [7:0]                     scanline_intensity,
    input  logic                           pixel_write,
    input  logic [pixel_address_width-1:0] pixel_write_address,
    input  pixel_t                         pixel_write_data,
    input  logic                           text_write,
    input  logic [text_address_width-1:0]  text_write_address,
    input  char_t                          text_write_data,
    output pixel_t                         video_out,
    output logic                           hsync,
    output logic                           vsync,
    output logic                           draw_area,
    output logic                           settled
);

    logic [pixel_address_width-1:0] pixel_read_address;
    pixel_t                         pixel_read_data;
    logic [text_address_width-1:0]  text_read_address;
    char_t                          text_read_data;

    // line buffer
    dual_port_ram #(
        .payload_t(pixel_t),
        .depth    (pixel_depth)
    ) pixel_ram (
        .clock        (clock),
        .write        (pixel_write),
        .write_address(pixel_write_address),
        .write_data   (pixel_write_data),
        .read_address (pixel_read_address),
        .read_data    (pixel_read_data)
    );

    // one row of osd characters
    dual_port_ram #(
        .payload_t(char_t),
        .depth    (text_columns)
    ) text_ram (
        .clock        (clock),
        .write        (text_write),
        .write_address(text_write_address),
        .write_data   (text_write_data),
        .read_address (text_read_address),
        .read_data    (text_read_data)
    );

    ram_to_video engine (
        .clock             (clock),
        .reset             (reset),
        .start_trigger     (start_trigger),
        .line_doubler      (line_doubler),
        .osd_enable        (osd_enable),
        .osd_highlight     (osd_highlight),
        .scanline_enable   (scanline_enable),
        .scanline_odd      (scanline_odd),
        .scanline_intensity(scanline_intensity),
        .pixel_read_data   (pixel_read_data),
        .text_read_data    (text_read_data),
        .pixel_read_address(pixel_read_address),
        .text_read_address (text_read_address),
        .video_out         (video_out),
        .hsync             (hsync),
        .vsync             (vsync),
        .draw_area         (draw_area),
        .settled           (settled)
    );

endmodule

// ==== logic/video_pkg.sv ====
package video_pkg;

    //////////////////////////////////////////////////////////////////////
    // horizontal timing, in clocks
    localparam int h_total = 40;
    localparam int h_visible = 32;
    localparam int hsync_start = 34;
    localparam int hsync_width = 3;
    localparam int h_count_width = $clog2(h_total);

    //////////////////////////////////////////////////////////////////////
    // vertical timing, in lines
    localparam int v_total = 24;
    localparam int v_visible = 16;
    localparam int vsync_start = 19;
    localparam int vsync_width = 2;
    localparam int v_count_width = $clog2(v_total);

    // sync pulses are active low
    localparam logic sync_active = 1'b0;

    // bundle order is draw, hsync, vsync
    localparam logic [2:0] sync_bundle_idle = {1'b0, ~sync_active, ~sync_active};

    //////////////////////////////////////////////////////////////////////
    // line buffer
    localparam int buffer_line_length = 32;
    localparam int pixel_depth = 512;
    localparam int pixel_address_width = $clog2(pixel_depth);

    // red in the high byte
    typedef logic [23:0] pixel_t;

    //////////////////////////////////////////////////////////////////////
    // on-screen display
    localparam int osd_x_start = 0;
    localparam int osd_x_end = 32;
    localparam int osd_y_start = 4;
    localparam int osd_y_end = 12;
    localparam int text_columns = 4;
    localparam int text_address_width = $clog2(text_columns);

    // only the low nibble selects a glyph
    typedef logic [7:0] char_t;

    localparam int glyph_rows = 8;
    localparam int glyph_row_width = $clog2(glyph_rows);
    localparam pixel_t osd_text_color = '1;

    //////////////////////////////////////////////////////////////////////
    // pipeline and start-up
    localparam int pixel_latency = 6;
    localparam int settle_frames = 3;

endpackage

// ==== testbench/tb_clock.sv ====
module tb_clock (
    output logic clock,
    output logic reset
);

    // 4 time units per period
    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    // release on a falling edge, away from the flops
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// ==== testbench/tb_video_out.sv ====
module tb_video_out
    import video_pkg::*;
();

    `include "glyph_font.svh"

    localparam int clock_period = 4;
    localparam int row_count = 6;
    localparam int frame_clocks = h_total * v_total;
    localparam int watchdog_clocks = 16 + pixel_depth + 7 * frame_clocks + 500;

    typedef struct packed {
        logic       line_doubler;
        logic       osd_enable;
        logic       osd_highlight;
        logic       scanline_enable;
        logic       scanline_odd;
        logic [7:0] intensity;
        logic [31:0] codes;
    } stim_row_t;

    logic clock;
    logic reset;
    logic start_trigger;
    logic line_doubler;
    logic osd_enable;
    logic osd_highlight;
    logic scanline_enable;
    logic scanline_odd;
    logic [7:0] scanline_intensity;
    logic pixel_write;
    logic [pixel_address_width-1:0] pixel_write_address;
    pixel_t pixel_write_data;
    logic text_write;
    logic [text_address_width-1:0] text_write_address;
    char_t text_write_data;
    pixel_t video_out;
    logic hsync;
    logic vsync;
    logic draw_area;
    logic settled;

    stim_row_t stimulus [row_count];
    pixel_t ram_model [pixel_depth];
    integer seed;

    // monitor state
    logic hsync_prev = 1'b1;
    logic vsync_prev = 1'b1;
    logic draw_prev = 1'b0;
    logic hsync_seen = 1'b0;
    logic vsync_seen = 1'b0;
    int clocks_since_hsync = 0;
    int clocks_since_vsync = 0;
    int hsync_length = 0;
    int vsync_length = 0;
    int vsync_starts = 0;
    int line_count = 0;
    int pos_x = 0;
    int pos_y = 0;
    int frame_row = 0;
    int pixels_checked = 0;

    tb_clock clocks (
        .clock(clock),
        .reset(reset)
    );

    video_out_top UUT (
        .clock              (clock),
        .reset              (reset),
        .start_trigger      (start_trigger),
        .line_doubler       (line_doubler),
        .osd_enable         (osd_enable),
        .osd_highlight      (osd_highlight),
        .scanline_enable    (scanline_enable),
        .scanline_odd       (scanline_odd),
        .scanline_intensity (scanline_intensity),
        .pixel_write        (pixel_write),
        .pixel_write_address(pixel_write_address),
        .pixel_write_data   (pixel_write_data),
        .text_write         (text_write),
        .text_write_address (text_write_address),
        .text_write_data    (text_write_data),
        .video_out          (video_out),
        .hsync              (hsync),
        .vsync              (vsync),
        .draw_area          (draw_area),
        .settled            (settled)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is %h, expected %h",
                $time, name, actual, expected);
            fail_run("an output differs from the reference model");
        end
    endtask

    // engine must look idle before the start strobe
    task automatic check_idle();
        check_value("hsync", hsync, 1);
        check_value("vsync", vsync, 1);
        check_value("draw_area", draw_area, 0);
        check_value("video_out", video_out, 0);
        check_value("settled", settled, 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model of one visible pixel
    function automatic pixel_t expected_pixel(input int row, input int px, input int py);
        stim_row_t s;
        int buffer_row;
        int product;
        pixel_t word;
        logic [7:0] code;
        logic [7:0] glyph;
        logic lit;
        pixel_t result;
        s = stimulus[row];
        buffer_row = s.line_doubler ? py / 2 : py;
        word = ram_model[buffer_row * buffer_line_length + px];
        if (s.osd_enable && py >= osd_y_start && py < osd_y_end
                && px >= osd_x_start && px < osd_x_end) begin
            code = s.codes[8 * (px / 8) +: 8];
            glyph = glyph_font[code[3:0] * glyph_rows + (py - osd_y_start)];
            lit = glyph[7 - px % 8] ^ s.osd_highlight;
            if (lit) begin
                result = osd_text_color;
            end else begin
                for (int ch = 0; ch < 3; ch++) begin
                    result[8 * ch +: 8] = word[8 * ch +: 8] / 2;
                end
            end
        end else if (s.scanline_enable && (buffer_row % 2) == s.scanline_odd) begin
            for (int ch = 0; ch < 3; ch++) begin
                product = int'(word[8 * ch +: 8]) * int'(s.intensity);
                result[8 * ch +: 8] = product / 256;
            end
        end else begin
            result = word;
        end
        return result;
    endfunction

    // text codes first, then the level inputs
    task automatic apply_row(input int row);
        for (int c = 0; c < text_columns; c++) begin
            @(negedge clock);
            text_write = 1'b1;
            text_write_address = c;
            text_write_data = stimulus[row].codes[8 * c +: 8];
        end
        @(negedge clock);
        text_write = 1'b0;
        line_doubler = stimulus[row].line_doubler;
        osd_enable = stimulus[row].osd_enable;
        osd_highlight = stimulus[row].osd_highlight;
        scanline_enable = stimulus[row].scanline_enable;
        scanline_odd = stimulus[row].scanline_odd;
        scanline_intensity = stimulus[row].intensity;
    endtask

    //////////////////////////////////////////////////////////////////////
    // port monitor, samples on falling edges
    always @(negedge clock) begin
        if (!reset) begin
            clocks_since_hsync++;
            if (hsync == 1'b0 && hsync_prev == 1'b1) begin
                if (hsync_seen) begin
                    check_value("hsync period", clocks_since_hsync, h_total);
                end
                hsync_seen = 1'b1;
                clocks_since_hsync = 0;
                hsync_length = 0;
            end
            if (hsync == 1'b0) begin
                hsync_length++;
            end
            if (hsync == 1'b1 && hsync_prev == 1'b0) begin
                check_value("hsync width", hsync_length, hsync_width);
            end

            clocks_since_vsync++;
            if (vsync == 1'b0 && vsync_prev == 1'b1) begin
                if (vsync_seen) begin
                    check_value("vsync period", clocks_since_vsync, frame_clocks);
                end
                check_value("draw lines", line_count, v_visible);
                vsync_seen = 1'b1;
                clocks_since_vsync = 0;
                vsync_length = 0;
                vsync_starts++;
                frame_row++;
            end
            if (vsync == 1'b0) begin
                vsync_length++;
            end
            if (vsync == 1'b1 && vsync_prev == 1'b0) begin
                check_value("vsync width", vsync_length, vsync_width * h_total);
                line_count = 0;
            end
            check_value("settled", settled, vsync_starts >= settle_frames);

            // position from the ports alone
            if (draw_area && !draw_prev) begin
                pos_y = line_count;
                line_count++;
                pos_x = 0;
            end
            if (draw_area) begin
                if (frame_row < row_count) begin
                    check_value("video_out", video_out,
                        expected_pixel(frame_row, pos_x, pos_y));
                end
                pixels_checked++;
                pos_x++;
            end else begin
                check_value("video_out", video_out, 0);
            end
            if (!draw_area && draw_prev) begin
                check_value("draw_area width", pos_x, h_visible);
            end

            hsync_prev = hsync;
            vsync_prev = vsync;
            draw_prev = draw_area;
        end
    end

    initial begin
        #(watchdog_clocks * clock_period);
        fail_run("Timeout: the run hung before all frames were checked");
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    initial begin
        start_trigger = 1'b0;
        line_doubler = 1'b0;
        osd_enable = 1'b0;
        osd_highlight = 1'b0;
        scanline_enable = 1'b0;
        scanline_odd = 1'b0;
        scanline_intensity = '0;
        pixel_write = 1'b0;
        pixel_write_address = '0;
        pixel_write_data = '0;
        text_write = 1'b0;
        text_write_address = '0;
        text_write_data = '0;
        seed = 54;

        // doubler, osd, highlight, scanline, odd, intensity, codes
        stimulus[0] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 32'h03020100};
        stimulus[1] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 32'h07060504};
        stimulus[2] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h80, 32'h3d2c1b0a};
        stimulus[3] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 8'h40, 32'hc3d2e1f0};
        stimulus[4] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 8'h60, 32'h00000000};
        stimulus[5] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 8'hc0, 32'hefcdab89};

        @(negedge reset);
        for (int a = 0; a < pixel_depth; a++) begin
            @(negedge clock);
            check_idle();
            ram_model[a] = pixel_t'($random(seed));
            pixel_write = 1'b1;
            pixel_write_address = a;
            pixel_write_data = ram_model[a];
        end
        @(negedge clock);
        pixel_write = 1'b0;
        apply_row(0);
        check_idle();

        @(negedge clock);
        start_trigger = 1'b1;
        @(negedge clock);
        start_trigger = 1'b0;

        // one frame per row, switched during vertical blanking
        for (int r = 1; r < row_count; r++) begin
            @(negedge vsync);
            apply_row(r);
            if (r == 3) begin
                // a second strobe must not restart the counters
                @(negedge clock);
                start_trigger = 1'b1;
                @(negedge clock);
                start_trigger = 1'b0;
            end
        end
        @(negedge vsync);
        repeat (4) @(negedge clock);

        check_value("pixels checked", pixels_checked, row_count * v_visible * h_visible);
        check_value("settled", settled, 1);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
